// File: logic/img_pkg.sv
`default_nettype none

package img_pkg;

    // ====================================================================
    // Stored words and sensor pixels
    // ====================================================================
    localparam int WORD_BITS = 16;
    typedef logic [WORD_BITS-1:0] word_t;

    localparam int PIXEL_BITS = 12;
    typedef logic [PIXEL_BITS-1:0] pixel_t;

    // Header that comes with the capture command, first word in the top bits
    localparam int HEADER_WORDS = 8;
    typedef logic [HEADER_WORDS*WORD_BITS-1:0] header_t;

    // Fletcher-32 appended after the frame
    localparam int CHECKSUM_WORDS = 2;

    // ====================================================================
    // Capture statistics
    // ====================================================================
    // Top pixel bits tested for highlight or shadow
    localparam int STAT_BITS = 7;
    // In-tile x and y counters, tile side 4
    localparam int TILE_BITS = 2;
    localparam int STAT_COUNT_BITS = 18;
    typedef logic [STAT_COUNT_BITS-1:0] stat_count_t;

endpackage

`default_nettype wire

// File: logic/store_pkg.sv
`default_nettype none

package store_pkg;

    // Two on-chip blocks, one frame per block
    localparam int BLOCKS = 2;
    typedef logic [$clog2(BLOCKS)-1:0] block_t;

    localparam int BLOCK_WORDS = 256;
    localparam int ADDR_BITS = $clog2(BLOCK_WORDS);
    typedef logic [ADDR_BITS-1:0] addr_t;

    // One bit wider than the address, so a full block fits
    typedef logic [ADDR_BITS:0] word_count_t;

    typedef enum logic [1:0] {
        STORE_IDLE,
        STORE_WRITE,
        STORE_READ
    } store_mode_t;

endpackage

`default_nettype wire

// File: logic/store_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface store_ctrl_if import store_pkg::*; ();

    store_mode_t mode;
    block_t      block;
    // One-cycle pulse, restarts the address for the current mode
    logic        start;
    // Words to deliver, taken when a read starts
    word_count_t read_count;
    // Level, high while nothing is left to read
    logic        read_done;

    modport ctrl (
        output mode,
        output block,
        output start,
        output read_count,
        input  read_done
    );

    modport store (
        input  mode,
        input  block,
        input  start,
        input  read_count,
        output read_done
    );

endinterface

`default_nettype wire

// File: logic/fletcher32.sv
`timescale 1ns/1ps
`default_nettype none

module fletcher32 import img_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear,
    input  logic                   en,
    input  word_t                  din,
    output logic [2*WORD_BITS-1:0] sum
);

    word_t sum_lo;
    word_t sum_hi;
    word_t lo_next;

    // Sum of two words modulo 65535
    function automatic word_t add_mod(input word_t a, input word_t b);
        logic [WORD_BITS:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, {WORD_BITS{1'b1}}}) begin
            s = s - {1'b0, {WORD_BITS{1'b1}}};
        end
        return s[WORD_BITS-1:0];
    endfunction

    assign lo_next = add_mod(sum_lo, din);

    // High sum accumulates the already updated low sum
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            sum_lo <= '0;
            sum_hi <= '0;
        end else if (en) begin
            sum_lo <= lo_next;
            sum_hi <= add_mod(sum_hi, lo_next);
        end
    end

    assign sum = {sum_hi, sum_lo};

endmodule

`default_nettype wire

// File: logic/frame_capture.sv
`timescale 1ns/1ps
`default_nettype none

module frame_capture import img_pkg::*, store_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  header_t     header,
    input  pixel_t      img_d,
    input  logic        img_fv,
    input  logic        img_lv,
    output logic        wr_en,
    output word_t       wr_data,
    output logic        done,
    output word_count_t word_count,
    output stat_count_t highlight_count,
    output stat_count_t shadow_count
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CLEAR,
        S_HEADER,
        S_WAIT_LOW,
        S_WAIT_HIGH,
        S_PIXELS,
        S_CHECKSUM
    } state_t;

    typedef logic [$clog2(HEADER_WORDS)-1:0] hdr_idx_t;
    typedef logic [$clog2(CHECKSUM_WORDS)-1:0] ck_idx_t;

    state_t                 state;
    header_t                hdr_shift;
    hdr_idx_t               hdr_idx;
    ck_idx_t                ck_idx;
    logic [TILE_BITS-1:0]   tile_x;
    logic [TILE_BITS-1:0]   tile_y;
    logic                   lv_prev;
    logic                   pix_wr;
    logic                   ck_en;
    word_t                  pix_word;
    word_t                  ck_din;
    logic [2*WORD_BITS-1:0] ck_sum;
    logic [STAT_BITS-1:0]   pix_top;

    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8]};
    endfunction

    // Pixel stored little-endian: low byte, then zero pad and high nibble
    assign pix_word = {img_d[7:0], {(WORD_BITS-PIXEL_BITS){1'b0}}, img_d[PIXEL_BITS-1:8]};
    assign pix_top  = img_d[PIXEL_BITS-1 -: STAT_BITS];

    // Pixel write also covers the cycle in which the frame opens
    assign pix_wr = img_fv && img_lv && (state == S_WAIT_HIGH || state == S_PIXELS);
    assign ck_en  = (state == S_HEADER) || pix_wr;
    assign wr_en  = ck_en || (state == S_CHECKSUM);
    assign ck_din = swap_bytes(wr_data);

    always_comb begin
        case (state)
            S_HEADER:   wr_data = hdr_shift[$bits(header_t)-1 -: WORD_BITS];
            S_CHECKSUM: wr_data = swap_bytes(ck_sum[ck_idx*WORD_BITS +: WORD_BITS]);
            default:    wr_data = pix_word;
        endcase
    end

    fletcher32 checksum (
        .clk   (clk),
        .rst   (rst),
        .clear (state == S_CLEAR),
        .en    (ck_en),
        .din   (ck_din),
        .sum   (ck_sum)
    );

    // ====================================================================
    // Tile position, x within a line and y over the lines of a frame
    // ====================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            lv_prev <= 1'b0;
            tile_x  <= '0;
            tile_y  <= '0;
        end else begin
            lv_prev <= img_lv;
            tile_x  <= img_lv ? tile_x + 1'b1 : '0;
            if (!img_fv) begin
                tile_y <= '0;
            end else if (lv_prev && !img_lv) begin
                tile_y <= tile_y + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            hdr_shift <= header;
        end else if (state == S_HEADER) begin
            hdr_shift <= hdr_shift << WORD_BITS;
        end
    end

    // ====================================================================
    // Capture sequence
    // ====================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= S_IDLE;
            hdr_idx         <= '0;
            ck_idx          <= '0;
            done            <= 1'b0;
            word_count      <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            done <= 1'b0;
            if (wr_en) begin
                word_count <= word_count + 1'b1;
            end
            // First pixel of each tile only
            if (pix_wr && tile_x == '0 && tile_y == '0) begin
                if (&pix_top) begin
                    highlight_count <= highlight_count + 1'b1;
                end else if (~|pix_top) begin
                    shadow_count <= shadow_count + 1'b1;
                end
            end
            case (state)
                S_IDLE: begin
                    if (start) state <= S_CLEAR;
                end
                S_CLEAR: begin
                    word_count      <= '0;
                    highlight_count <= '0;
                    shadow_count    <= '0;
                    hdr_idx         <= '0;
                    ck_idx          <= '0;
                    state           <= S_HEADER;
                end
                S_HEADER: begin
                    hdr_idx <= hdr_idx + 1'b1;
                    if (hdr_idx == hdr_idx_t'(HEADER_WORDS - 1)) state <= S_WAIT_LOW;
                end
                S_WAIT_LOW: begin
                    if (!img_fv) state <= S_WAIT_HIGH;
                end
                S_WAIT_HIGH: begin
                    if (img_fv) state <= S_PIXELS;
                end
                S_PIXELS: begin
                    if (!img_fv) state <= S_CHECKSUM;
                end
                S_CHECKSUM: begin
                    ck_idx <= ck_idx + 1'b1;
                    if (ck_idx == ck_idx_t'(CHECKSUM_WORDS - 1)) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/word_store.sv
`timescale 1ns/1ps
`default_nettype none

module word_store import img_pkg::*, store_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    store_ctrl_if.store ctrl,
    input  logic        wr_en,
    input  word_t       wr_data,
    output logic        rd_ready,
    input  logic        rd_trigger,
    output word_t       rd_data
);

    word_t mem [BLOCKS][BLOCK_WORDS];

    word_count_t wr_count;
    addr_t       rd_addr;
    word_count_t rd_left;
    logic        rd_valid;
    logic        write_mode;
    logic        read_mode;
    logic        mem_we;
    logic        fetch;
    word_count_t read_len;

    assign write_mode = (ctrl.mode == STORE_WRITE);
    assign read_mode  = (ctrl.mode == STORE_READ);

    // Writes past the end of a block are dropped
    assign mem_we = write_mode && wr_en && !ctrl.start
                    && (wr_count < word_count_t'(BLOCK_WORDS));

    // Next word is fetched once the holding register is empty
    assign fetch = read_mode && !ctrl.start && !rd_valid && (rd_left != '0);

    assign read_len = (ctrl.read_count > word_count_t'(BLOCK_WORDS))
                      ? word_count_t'(BLOCK_WORDS) : ctrl.read_count;

    // ====================================================================
    // Memory array, one-cycle read straight into the holding register
    // ====================================================================
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[ctrl.block][wr_count[ADDR_BITS-1:0]] <= wr_data;
        end
        if (fetch) begin
            rd_data <= mem[ctrl.block][rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_count <= '0;
        end else if (write_mode && ctrl.start) begin
            wr_count <= '0;
        end else if (mem_we) begin
            wr_count <= wr_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_addr  <= '0;
            rd_left  <= '0;
            rd_valid <= 1'b0;
        end else if (read_mode && ctrl.start) begin
            rd_addr  <= '0;
            rd_left  <= read_len;
            rd_valid <= 1'b0;
        end else if (fetch) begin
            rd_addr  <= rd_addr + 1'b1;
            rd_left  <= rd_left - 1'b1;
            rd_valid <= 1'b1;
        end else if (rd_valid && rd_trigger) begin
            rd_valid <= 1'b0;
        end
    end

    assign rd_ready = rd_valid;
    // Done only after the last word has also been taken by the reader
    assign ctrl.read_done = (rd_left == '0) && !rd_valid;

endmodule

`default_nettype wire

// File: logic/capture_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module capture_ctrl import store_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_capture,
    input  logic        cmd_readout,
    input  block_t      cmd_block,
    store_ctrl_if.ctrl  store,
    output logic        capture_start,
    input  logic        capture_done_in,
    input  word_count_t capture_words,
    output logic        readout_start,
    output logic        capture_done,
    output word_count_t capture_word_count
);

    typedef enum logic [1:0] {
        C_IDLE,
        C_CAPTURE,
        C_READOUT
    } state_t;

    state_t      state;
    word_count_t last_words;

    // Capture sequencer leaves idle in the command cycle itself
    assign capture_start = (state == C_IDLE) && cmd_capture;
    assign capture_done  = (state == C_CAPTURE) && capture_done_in;

    // Fresh count in the done cycle, the kept one afterwards
    assign capture_word_count = capture_done ? capture_words : last_words;
    assign store.read_count   = last_words;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= C_IDLE;
            store.mode    <= STORE_IDLE;
            store.block   <= '0;
            store.start   <= 1'b0;
            readout_start <= 1'b0;
            last_words    <= '0;
        end else begin
            store.start   <= 1'b0;
            readout_start <= 1'b0;
            case (state)
                C_IDLE: begin
                    if (cmd_capture) begin
                        store.mode  <= STORE_WRITE;
                        store.block <= cmd_block;
                        store.start <= 1'b1;
                        state       <= C_CAPTURE;
                    end else if (cmd_readout) begin
                        store.mode    <= STORE_READ;
                        store.block   <= cmd_block;
                        store.start   <= 1'b1;
                        readout_start <= 1'b1;
                        state         <= C_READOUT;
                    end
                end
                C_CAPTURE: begin
                    if (capture_done_in) begin
                        last_words <= capture_words;
                        store.mode <= STORE_IDLE;
                        state      <= C_IDLE;
                    end
                end
                C_READOUT: begin
                    // read_done is stale until the store has taken the start
                    if (!store.start && store.read_done) begin
                        store.mode <= STORE_IDLE;
                        state      <= C_IDLE;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/img_controller.sv
`timescale 1ns/1ps
`default_nettype none

module img_controller import img_pkg::*, store_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // Commands
    input  logic        cmd_capture,
    input  logic        cmd_readout,
    input  block_t      cmd_block,
    input  header_t     cmd_header,

    // Image sensor
    input  pixel_t      img_d,
    input  logic        img_fv,
    input  logic        img_lv,

    // Status
    output logic        capture_done,
    output word_count_t capture_word_count,
    output stat_count_t highlight_count,
    output stat_count_t shadow_count,

    // Readout
    output logic        readout_start,
    output logic        readout_ready,
    input  logic        readout_trigger,
    output word_t       readout_data
);

    logic        capture_start;
    logic        frame_done;
    word_count_t frame_words;
    logic        wr_en;
    word_t       wr_data;

    store_ctrl_if store_ctrl ();

    capture_ctrl ctrl (
        .clk                (clk),
        .rst                (rst),
        .cmd_capture        (cmd_capture),
        .cmd_readout        (cmd_readout),
        .cmd_block          (cmd_block),
        .store              (store_ctrl.ctrl),
        .capture_start      (capture_start),
        .capture_done_in    (frame_done),
        .capture_words      (frame_words),
        .readout_start      (readout_start),
        .capture_done       (capture_done),
        .capture_word_count (capture_word_count)
    );

    frame_capture capture (
        .clk             (clk),
        .rst             (rst),
        .start           (capture_start),
        .header          (cmd_header),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .wr_en           (wr_en),
        .wr_data         (wr_data),
        .done            (frame_done),
        .word_count      (frame_words),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    word_store store (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (store_ctrl.store),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .rd_ready   (readout_ready),
        .rd_trigger (readout_trigger),
        .rd_data    (readout_data)
    );

endmodule

`default_nettype wire

// File: tb/img_controller_props.sv
`timescale 1ns/1ps
`default_nettype none

module img_controller_props import img_pkg::*, store_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        capture_done,
    input word_count_t capture_word_count,
    input stat_count_t highlight_count,
    input stat_count_t shadow_count,
    input logic        readout_start,
    input logic        readout_ready,
    input logic        readout_trigger,
    input word_t       readout_data
);

    // Status pulses last a single cycle
    assert property (@(posedge clk) disable iff (rst) capture_done |=> !capture_done)
        else $error("capture_done held high for more than one cycle");

    assert property (@(posedge clk) disable iff (rst) readout_start |=> !readout_start)
        else $error("readout_start held high for more than one cycle");

    // Ready drops after a taken word while the next one is fetched
    assert property (@(posedge clk) disable iff (rst)
        (readout_ready && readout_trigger) |=> !readout_ready)
        else $error("readout_ready stayed high after a consumed word");

    // An offered word waits for the reader
    assert property (@(posedge clk) disable iff (rst)
        (readout_ready && !readout_trigger) |=> readout_ready && $stable(readout_data))
        else $error("offered readout word changed or vanished before trigger");

    assert property (@(posedge clk) disable iff (rst)
        !(capture_done && (readout_start || readout_ready)))
        else $error("capture completion overlaps a readout");

    // Status is cleared by reset
    assert property (@(posedge clk) rst |=> !capture_done && !readout_start && !readout_ready
        && capture_word_count == '0 && highlight_count == '0 && shadow_count == '0)
        else $error("status not cleared by reset");

endmodule

`default_nettype wire

// File: tb/img_controller_tb.sv
`timescale 1ns/1ps
`default_nettype none

module img_controller_tb import img_pkg::*, store_pkg::*;;

    localparam int CLK_PERIOD   = 40;
    localparam int LINES        = 8;
    localparam int WIDTH        = 12;
    localparam int FRAME_PIXELS = LINES * WIDTH;
    localparam int FRAME_WORDS  = HEADER_WORDS + FRAME_PIXELS + CHECKSUM_WORDS;
    localparam int FRAME_CYCLES = 16 + LINES * (WIDTH + 3);
    localparam int READ_CYCLES  = 4 * FRAME_WORDS + 8;
    localparam int STIM_CYCLES  = 8 + 2 * FRAME_CYCLES + 2 * READ_CYCLES;
    localparam logic [31:0] SEED = 32'h8c019a3a;

    logic        clk = 1'b0;
    logic        rst;
    logic        cmd_capture;
    logic        cmd_readout;
    block_t      cmd_block;
    header_t     cmd_header;
    pixel_t      img_d;
    logic        img_fv;
    logic        img_lv;
    logic        capture_done;
    word_count_t capture_word_count;
    stat_count_t highlight_count;
    stat_count_t shadow_count;
    logic        readout_start;
    logic        readout_ready;
    logic        readout_trigger;
    word_t       readout_data;

    // Reference model of both blocks and of the current frame
    word_t       model_mem [BLOCKS][BLOCK_WORDS];
    pixel_t      frame_pix [FRAME_PIXELS];
    header_t     frame_hdr;
    logic [31:0] lfsr;
    word_count_t exp_words;
    stat_count_t exp_high;
    stat_count_t exp_shadow;
    int          last_words;
    block_t      read_block;
    int          read_idx;
    int          read_len;
    logic        cmd_seen;
    word_t       expected_word;

    always #(CLK_PERIOD / 2) clk = ~clk;

    img_controller UUT (
        .clk                (clk),
        .rst                (rst),
        .cmd_capture        (cmd_capture),
        .cmd_readout        (cmd_readout),
        .cmd_block          (cmd_block),
        .cmd_header         (cmd_header),
        .img_d              (img_d),
        .img_fv             (img_fv),
        .img_lv             (img_lv),
        .capture_done       (capture_done),
        .capture_word_count (capture_word_count),
        .highlight_count    (highlight_count),
        .shadow_count       (shadow_count),
        .readout_start      (readout_start),
        .readout_ready      (readout_ready),
        .readout_trigger    (readout_trigger),
        .readout_data       (readout_data)
    );

    bind img_controller img_controller_props props (
        .clk                (clk),
        .rst                (rst),
        .capture_done       (capture_done),
        .capture_word_count (capture_word_count),
        .highlight_count    (highlight_count),
        .shadow_count       (shadow_count),
        .readout_start      (readout_start),
        .readout_ready      (readout_ready),
        .readout_trigger    (readout_trigger),
        .readout_data       (readout_data)
    );

    always_comb expected_word = model_mem[read_block][read_idx[ADDR_BITS-1:0]];

    function automatic void abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endfunction

    // ====================================================================
    // Checks
    // ====================================================================
    assert property (@(posedge clk) disable iff (rst)
        !cmd_seen |-> !capture_done && !readout_start && !readout_ready)
        else abort_run($sformatf("[FAIL] %0t status active before any command", $time));

    assert property (@(posedge clk) disable iff (rst)
        cmd_readout |=> readout_start)
        else abort_run($sformatf("[FAIL] %0t readout_start missing after readout command",
                                 $time));

    assert property (@(posedge clk) disable iff (rst)
        capture_done |-> capture_word_count == exp_words)
        else abort_run($sformatf("[FAIL] %0t word count %0d, expected %0d",
                                 $time, capture_word_count, exp_words));

    assert property (@(posedge clk) disable iff (rst)
        capture_done |-> highlight_count == exp_high && shadow_count == exp_shadow)
        else abort_run($sformatf("[FAIL] %0t highlight %0d shadow %0d, expected %0d %0d",
                                 $time, highlight_count, shadow_count, exp_high, exp_shadow));

    assert property (@(posedge clk) disable iff (rst)
        (readout_trigger && readout_ready) |-> readout_data == expected_word)
        else abort_run($sformatf("[FAIL] %0t block %0d word %0d is %h, expected %h",
                                 $time, read_block, read_idx, readout_data, expected_word));

    assert property (@(posedge clk) disable iff (rst)
        (read_idx == read_len) |-> !readout_ready)
        else abort_run($sformatf("[FAIL] %0t readout_ready high after the last word", $time));

    // ====================================================================
    // Stimulus and model
    // ====================================================================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic word_t byte_swap(input word_t w);
        return {w[7:0], w[15:8]};
    endfunction

    task automatic build_frame(input block_t blk, input int seq);
        logic [31:0]          bits;
        logic [STAT_BITS-1:0] top;
        word_t                w;
        int                   lo;
        int                   hi;
        int                   x;
        int                   y;
        lo = 0;
        hi = 0;
        exp_high = '0;
        exp_shadow = '0;
        for (int i = 0; i < HEADER_WORDS; i++) begin
            draw_bits(WORD_BITS, bits);
            w = bits[WORD_BITS-1:0];
            frame_hdr[(HEADER_WORDS-1-i)*WORD_BITS +: WORD_BITS] = w;
            model_mem[blk][i] = w;
            lo = (lo + byte_swap(w)) % 65535;
            hi = (hi + lo) % 65535;
        end
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            x = i % WIDTH;
            y = i / WIDTH;
            draw_bits(PIXEL_BITS, bits);
            // First pixel of a 4x4 tile, some forced to highlight or shadow
            if (x % 4 == 0 && y % 4 == 0) begin
                case ((x / 4 + y / 4 + seq) % 3)
                    0: bits[PIXEL_BITS-1 -: STAT_BITS] = '1;
                    1: bits[PIXEL_BITS-1 -: STAT_BITS] = '0;
                    default: ;
                endcase
                top = bits[PIXEL_BITS-1 -: STAT_BITS];
                if (&top) begin
                    exp_high = exp_high + 1'b1;
                end else if (top == '0) begin
                    exp_shadow = exp_shadow + 1'b1;
                end
            end
            frame_pix[i] = bits[PIXEL_BITS-1:0];
            // Little-endian word, low byte first
            w = byte_swap(word_t'(bits[PIXEL_BITS-1:0]));
            model_mem[blk][HEADER_WORDS+i] = w;
            lo = (lo + byte_swap(w)) % 65535;
            hi = (hi + lo) % 65535;
        end
        model_mem[blk][HEADER_WORDS+FRAME_PIXELS]   = byte_swap(word_t'(lo));
        model_mem[blk][HEADER_WORDS+FRAME_PIXELS+1] = byte_swap(word_t'(hi));
        exp_words = word_count_t'(FRAME_WORDS);
    endtask

    task automatic capture_frame(input block_t blk, input int seq);
        int waited;
        build_frame(blk, seq);
        cmd_capture <= 1'b1;
        cmd_block   <= blk;
        cmd_header  <= frame_hdr;
        cmd_seen    <= 1'b1;
        @(posedge clk);
        cmd_capture <= 1'b0;
        // Header goes out while the frame is still closed
        repeat (HEADER_WORDS + 4) @(posedge clk);
        img_fv <= 1'b1;
        @(posedge clk);
        for (int y = 0; y < LINES; y++) begin
            for (int x = 0; x < WIDTH; x++) begin
                img_lv <= 1'b1;
                img_d  <= frame_pix[y*WIDTH+x];
                @(posedge clk);
            end
            img_lv <= 1'b0;
            repeat (1 + y % 3) @(posedge clk);
        end
        img_fv <= 1'b0;
        waited = 0;
        while (!capture_done && waited < FRAME_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (!capture_done) begin
            abort_run($sformatf("capture_done never came for block %0d", blk));
        end
        last_words = FRAME_WORDS;
        repeat (3) @(posedge clk);
    endtask

    task automatic read_block_back(input block_t blk);
        logic [31:0] pace;
        int          taken;
        int          waited;
        read_block  <= blk;
        read_len    <= last_words;
        read_idx    <= 0;
        cmd_readout <= 1'b1;
        cmd_block   <= blk;
        cmd_seen    <= 1'b1;
        @(posedge clk);
        cmd_readout <= 1'b0;
        taken = 0;
        waited = 0;
        while (taken < last_words && waited < 2 * READ_CYCLES) begin
            @(posedge clk);
            waited++;
            draw_bits(1, pace);
            if (readout_trigger && readout_ready) begin
                taken++;
                read_idx        <= taken;
                readout_trigger <= 1'b0;
            end else begin
                // Reader holds back now and then
                readout_trigger <= readout_ready && pace[0];
            end
        end
        if (taken < last_words) begin
            abort_run($sformatf("readout of block %0d stalled after %0d words", blk, taken));
        end
        readout_trigger <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    initial begin
        lfsr = SEED;
        last_words = 0;
        exp_words = '0;
        exp_high = '0;
        exp_shadow = '0;
        rst             <= 1'b1;
        cmd_capture     <= 1'b0;
        cmd_readout     <= 1'b0;
        cmd_block       <= '0;
        cmd_header      <= '0;
        img_d           <= '0;
        img_fv          <= 1'b0;
        img_lv          <= 1'b0;
        readout_trigger <= 1'b0;
        read_block      <= '0;
        read_idx        <= 0;
        read_len        <= 0;
        cmd_seen        <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // Quiet stretch before the first command
        repeat (6) @(posedge clk);
        capture_frame(1'b0, 0);
        capture_frame(1'b1, 1);
        read_block_back(1'b0);
        read_block_back(1'b1);
        $display("TEST OK");
        $finish;
    end

    // Watchdog
    initial begin
        #(20 * STIM_CYCLES * CLK_PERIOD);
        abort_run($sformatf("Timeout, the run did not finish by %0t", $time));
    end

endmodule

`default_nettype wire

// File: build.f
logic/img_pkg.sv
logic/store_pkg.sv
logic/store_ctrl_if.sv
logic/fletcher32.sv
logic/frame_capture.sv
logic/word_store.sv
logic/capture_ctrl.sv
logic/img_controller.sv
tb/img_controller_props.sv
tb/img_controller_tb.sv

// File: Makefile
TOP = img_controller_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
